/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := jstkNavTb
FILELIST := jstkNavTop.f
OBJDIR   := obj_dir

BIN  := $(OBJDIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Exit status of the simulator is the test result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJDIR)

/* include/jstkNav_defines.svh */
`ifndef JSTKNAV_DEFINES_SVH
`define JSTKNAV_DEFINES_SVH

// ============================================================================
// Polling and SPI timing, in CLK cycles
// ============================================================================

// Clocks between poll starts
`define JSTK_POLL_CYCLES 4000

// SCLK half period, one SCLK period is twice this
`define JSTK_SCLK_HALF 4

// Bytes read per poll
`define JSTK_FRAME_BYTES 5

// ============================================================================
// Key thresholds and repeat timing
// ============================================================================

// Center band is LOW_TH <= pos <= HIGH_TH
`define JSTK_LOW_TH 300
`define JSTK_HIGH_TH 700

// Delay from first key pulse to first repeat
`define JSTK_HOLD_CYCLES 3000

// Spacing of repeat pulses
`define JSTK_REPEAT_CYCLES 1000

`endif

/* jstkNavTop.f */
+incdir+include
rtl/jstkNavPkg.sv
rtl/spiByteIf.sv
rtl/spiByteShifter.sv
rtl/jstkPoller.sv
rtl/axisRepeat.sv
rtl/jstkNavTop.sv
verif/jstkNav_chk.sv
verif/jstkNavTb.sv

/* rtl/axisRepeat.sv */
`timescale 1ns/1ps
`include "jstkNav_defines.svh"

module axisRepeat (
    input  logic             CLK,
    input  logic             RST,
    input  jstkNavPkg::pos_t pos,
    output logic             lowKey,  // Pulse below low threshold
    output logic             highKey  // Pulse above high threshold
);

    localparam int CntW = $clog2(`JSTK_HOLD_CYCLES + `JSTK_REPEAT_CYCLES);

    jstkNavPkg::axisState_e state, nextState;

    logic [CntW-1:0] cnt, nextCnt;   // Hold and repeat timer
    logic            nextLow, nextHigh;
    logic            isLow, isHigh;  // Outside the center band
    logic            holdDone, repeatDone;

    assign isLow      = (pos < jstkNavPkg::pos_t'(`JSTK_LOW_TH));
    assign isHigh     = (pos > jstkNavPkg::pos_t'(`JSTK_HIGH_TH));
    assign holdDone   = (cnt == CntW'(`JSTK_HOLD_CYCLES - 1));
    assign repeatDone = (cnt == CntW'(`JSTK_REPEAT_CYCLES - 1));

    // ========================================================================
    // Next state
    // ========================================================================

    // Pulses at crossing, crossing + HOLD, then every REPEAT
    always_comb begin
        nextState = state;
        nextCnt   = cnt + 1'b1;
        nextLow   = 1'b0;
        nextHigh  = 1'b0;
        case (state)
            jstkNavPkg::AxisCenter: begin
                nextCnt = '0;
                if (isHigh) begin
                    nextState = jstkNavPkg::AxisHighWait;
                    nextHigh  = 1'b1;             // Immediate pulse
                end else if (isLow) begin
                    nextState = jstkNavPkg::AxisLowWait;
                    nextLow   = 1'b1;
                end
            end
            jstkNavPkg::AxisLowWait, jstkNavPkg::AxisLowRepeat: begin
                if (!isLow) begin
                    nextState = jstkNavPkg::AxisCenter;  // Back in band
                end else if ((state == jstkNavPkg::AxisLowWait) ? holdDone : repeatDone) begin
                    nextState = jstkNavPkg::AxisLowRepeat;
                    nextCnt   = '0;
                    nextLow   = 1'b1;
                end
            end
            jstkNavPkg::AxisHighWait, jstkNavPkg::AxisHighRepeat: begin
                if (!isHigh) begin
                    nextState = jstkNavPkg::AxisCenter;
                end else if ((state == jstkNavPkg::AxisHighWait) ? holdDone : repeatDone) begin
                    nextState = jstkNavPkg::AxisHighRepeat;
                    nextCnt   = '0;
                    nextHigh  = 1'b1;
                end
            end
            default: nextState = jstkNavPkg::AxisCenter;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            state   <= jstkNavPkg::AxisCenter;
            cnt     <= '0;
            lowKey  <= 1'b0;
            highKey <= 1'b0;
        end else begin
            state   <= nextState;
            cnt     <= nextCnt;
            lowKey  <= nextLow;   // Registered, one cycle after pos
            highKey <= nextHigh;
        end
    end

endmodule

/* rtl/jstkNavPkg.sv */
package jstkNavPkg;

    // ========================================================================
    // Data types
    // ========================================================================

    typedef logic [9:0] pos_t;  // Joystick position, 512 is center
    typedef logic [7:0] byte_t; // One SPI byte

    // ========================================================================
    // State encodings
    // ========================================================================

    // Frame level sequence in the poller
    typedef enum logic [2:0] {
        PollIdle,  // Waiting for poll tick, SS high
        PollStart, // Request one byte
        PollWait,  // Byte in flight
        PollStore, // Shift received byte into frame
        PollDone   // Release SS and decode
    } pollState_e;

    // Single byte SPI engine
    typedef enum logic [1:0] {
        ShiftIdle,
        ShiftShift,  // SCLK toggling
        ShiftFinish  // Hand byte back
    } shiftState_e;

    // Per axis key logic
    typedef enum logic [2:0] {
        AxisCenter,
        AxisLowWait,    // Below low threshold, hold delay running
        AxisLowRepeat,  // Below low threshold, auto-repeat
        AxisHighWait,   // Above high threshold, hold delay running
        AxisHighRepeat  // Above high threshold, auto-repeat
    } axisState_e;

endpackage

/* rtl/jstkNavTop.sv */
`timescale 1ns/1ps

module jstkNavTop (
    input  logic CLK,
    input  logic RST,
    input  logic MISO,      // From joystick
    output logic SS,        // Slave select, active low
    output logic SCLK,
    output logic MOSI,
    output logic left,      // Key pulses
    output logic right,
    output logic up,
    output logic down,
    output logic click,     // Button levels from last frame
    output logic downClick
);

    jstkNavPkg::pos_t xPos; // Decoded positions
    jstkNavPkg::pos_t yPos;

    spiByteIf byteBus ();

    // No command byte is sent, MOSI stays low
    assign MOSI = 1'b0;

    // ========================================================================
    // SPI read path
    // ========================================================================

    jstkPoller i_poller (
        .CLK       (CLK),
        .RST       (RST),
        .bus       (byteBus.ctrl),
        .SS        (SS),
        .xPos      (xPos),
        .yPos      (yPos),
        .click     (click),
        .downClick (downClick)
    );

    spiByteShifter i_shifter (
        .CLK  (CLK),
        .RST  (RST),
        .MISO (MISO),
        .bus  (byteBus.eng),
        .SCLK (SCLK)
    );

    // ========================================================================
    // Key logic, one instance per axis
    // ========================================================================

    // X low is left, X high is right
    axisRepeat i_axisX (
        .CLK     (CLK),
        .RST     (RST),
        .pos     (xPos),
        .lowKey  (left),
        .highKey (right)
    );

    // Y low is up, Y high is down
    axisRepeat i_axisY (
        .CLK     (CLK),
        .RST     (RST),
        .pos     (yPos),
        .lowKey  (up),
        .highKey (down)
    );

endmodule

/* rtl/jstkPoller.sv */
`timescale 1ns/1ps
`include "jstkNav_defines.svh"

module jstkPoller (
    input  logic             CLK,
    input  logic             RST,
    spiByteIf.ctrl           bus,
    output logic             SS,        // Low for the whole frame
    output jstkNavPkg::pos_t xPos,
    output jstkNavPkg::pos_t yPos,
    output logic             click,     // Bit 0 of byte 5
    output logic             downClick  // Bit 1 of byte 5
);

    localparam int PollW  = $clog2(`JSTK_POLL_CYCLES);
    localparam int CntW   = $clog2(`JSTK_FRAME_BYTES + 1);
    localparam int FrameW = 8 * `JSTK_FRAME_BYTES;

    jstkNavPkg::pollState_e state;

    logic [PollW-1:0]  pollCnt;  // Free running poll timer
    logic              pollTick;
    logic [CntW-1:0]   byteCnt;  // Bytes stored this frame
    logic [FrameW-1:0] frameSr;  // Byte 1 ends up in the top byte

    // ========================================================================
    // Poll timer
    // ========================================================================

    assign pollTick = (pollCnt == PollW'(`JSTK_POLL_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (RST) begin
            pollCnt <= '0;
        end else if (pollTick) begin
            pollCnt <= '0;                // Wrap, one tick per period
        end else begin
            pollCnt <= pollCnt + 1'b1;
        end
    end

    // Request only when the engine is free
    assign bus.start = (state == jstkNavPkg::PollStart) && !bus.busy;

    // ========================================================================
    // Frame sequence
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= jstkNavPkg::PollIdle;
            SS        <= 1'b1;
            byteCnt   <= '0;
            xPos      <= jstkNavPkg::pos_t'(512); // Centered until first frame
            yPos      <= jstkNavPkg::pos_t'(512);
            click     <= 1'b0;
            downClick <= 1'b0;
        end else begin
            case (state)
                jstkNavPkg::PollIdle: begin
                    if (pollTick) begin       // Ticks elsewhere are dropped
                        SS      <= 1'b0;
                        byteCnt <= '0;
                        state   <= jstkNavPkg::PollStart;
                    end
                end
                jstkNavPkg::PollStart: begin
                    if (!bus.busy) begin
                        state <= jstkNavPkg::PollWait;
                    end
                end
                jstkNavPkg::PollWait: begin
                    if (bus.rxValid) begin    // Byte complete
                        state <= jstkNavPkg::PollStore;
                    end
                end
                jstkNavPkg::PollStore: begin
                    byteCnt <= byteCnt + 1'b1;
                    if (byteCnt == CntW'(`JSTK_FRAME_BYTES - 1)) begin
                        state <= jstkNavPkg::PollDone;
                    end else begin
                        state <= jstkNavPkg::PollStart; // Next byte
                    end
                end
                jstkNavPkg::PollDone: begin
                    SS        <= 1'b1;
                    // Low byte first on the wire, top 2 bits follow
                    yPos      <= {frameSr[25:24], frameSr[39:32]};
                    xPos      <= {frameSr[9:8], frameSr[23:16]};
                    click     <= frameSr[0];
                    downClick <= frameSr[1];
                    state     <= jstkNavPkg::PollIdle;
                end
                default: state <= jstkNavPkg::PollIdle;
            endcase
        end
    end

    // Frame assembly, shift in arrival order
    always_ff @(posedge CLK) begin
        if (state == jstkNavPkg::PollStore) begin
            frameSr <= {frameSr[FrameW-9:0], bus.rxByte};
        end
    end

endmodule

/* rtl/spiByteIf.sv */
`timescale 1ns/1ps

// Byte request and return between poller and SPI engine
interface spiByteIf;

    logic              start;   // One cycle request, only while busy low
    logic              busy;    // High the cycle after start until byte done
    logic              rxValid; // One cycle, first cycle with busy low again
    jstkNavPkg::byte_t rxByte;  // Received byte, held until next start

    // Poller side
    modport ctrl (
        output start,
        input  busy,
        input  rxValid,
        input  rxByte
    );

    // SPI engine side
    modport eng (
        input  start,
        output busy,
        output rxValid,
        output rxByte
    );

endinterface

/* rtl/spiByteShifter.sv */
`timescale 1ns/1ps
`include "jstkNav_defines.svh"

module spiByteShifter (
    input  logic   CLK,
    input  logic   RST,
    input  logic   MISO,
    spiByteIf.eng  bus,
    output logic   SCLK   // Idles low, mode 0
);

    localparam int HalfW = $clog2(`JSTK_SCLK_HALF + 1);

    jstkNavPkg::shiftState_e state;

    logic [HalfW-1:0]  halfCnt;  // Clocks within one SCLK half period
    logic              halfTick; // Last clock of a half period
    logic [3:0]        edgeCnt;  // SCLK edges, 16 per byte
    jstkNavPkg::byte_t rxSr;     // MSB arrives first

    assign halfTick   = (halfCnt == HalfW'(`JSTK_SCLK_HALF - 1));
    assign bus.rxByte = rxSr;    // Stable once shifting stops

    // ========================================================================
    // Byte sequencer and SCLK generation
    // ========================================================================

    always_ff @(posedge CLK) begin
        if (RST) begin
            state       <= jstkNavPkg::ShiftIdle;
            bus.busy    <= 1'b0;
            bus.rxValid <= 1'b0;
            SCLK        <= 1'b0;
            halfCnt     <= '0;
            edgeCnt     <= '0;
        end else begin
            bus.rxValid <= 1'b0;                  // Pulse only
            case (state)
                jstkNavPkg::ShiftIdle: begin
                    halfCnt <= '0;
                    edgeCnt <= '0;
                    if (bus.start) begin
                        bus.busy <= 1'b1;         // Visible the next cycle
                        state    <= jstkNavPkg::ShiftShift;
                    end
                end
                jstkNavPkg::ShiftShift: begin
                    if (halfTick) begin
                        halfCnt <= '0;
                        SCLK    <= ~SCLK;
                        edgeCnt <= edgeCnt + 1'b1;
                        // Sixteenth edge returns SCLK low
                        if (edgeCnt == 4'd15) begin
                            state <= jstkNavPkg::ShiftFinish;
                        end
                    end else begin
                        halfCnt <= halfCnt + 1'b1;
                    end
                end
                jstkNavPkg::ShiftFinish: begin
                    // rxValid rises with busy falling
                    bus.busy    <= 1'b0;
                    bus.rxValid <= 1'b1;
                    state       <= jstkNavPkg::ShiftIdle;
                end
                default: state <= jstkNavPkg::ShiftIdle;
            endcase
        end
    end

    // ========================================================================
    // Receive shift register
    // ========================================================================

    // Sample MISO on the clock where SCLK rises
    always_ff @(posedge CLK) begin
        if ((state == jstkNavPkg::ShiftShift) && halfTick && !SCLK) begin
            rxSr <= {rxSr[6:0], MISO};
        end
    end

endmodule

/* verif/jstkNavTb.sv */
`timescale 1ns/1ps
`include "jstkNav_defines.svh"

module jstkNavTb;

    localparam int Poll  = `JSTK_POLL_CYCLES;
    localparam int NameW = 8 * 24;          // Test names up to 24 chars

    logic CLK = 1'b0;
    logic RST;
    logic MISO;
    logic SS;
    logic SCLK;
    logic MOSI;
    logic left;
    logic right;
    logic up;
    logic down;
    logic click;
    logic downClick;

    logic [NameW-1:0] nameQ[$];             // One entry per stim line
    logic [39:0]      frameQ[$];            // Byte 1 in the top byte
    int               pollQ[$];

    logic [31:0] lfsr = 32'h0400_ce09;
    logic [39:0] curFrame;                  // Frame the slave sends next
    logic [39:0] slaveSr;
    logic        prevSs = 1'b1;
    logic        prevSclk = 1'b0;
    int          cycles;                    // Cycles spent waiting on frames
    int          cycleLimit;
    int          cntLeft;                   // Pulses seen in the current window
    int          cntRight;
    int          cntUp;
    int          cntDown;

    jstkNavTop i_jstkNavTop (.*);

    always #4 CLK = ~CLK;                   // 8 ns period

    // ========================================================================
    // Joystick slave model
    // ========================================================================

    // MSB first, next bit one clock after each SCLK fall
    always @(posedge CLK) begin
        prevSs   <= SS;
        prevSclk <= SCLK;
        if (prevSs && !SS) begin
            slaveSr <= curFrame;
            MISO    <= curFrame[39];
        end else if (!SS && prevSclk && !SCLK) begin
            slaveSr <= {slaveSr[38:0], 1'b0};
            MISO    <= slaveSr[38];
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    task automatic abortRun(input string why);
        $display("Test FAILED");
        $fatal(1, "%0s", why);
    endtask

    // Taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic randomBits(input int n, output logic [7:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsrStep(lfsr);          // One step per bit
            bits = {bits[6:0], lfsr[31]};
        end
    endtask

    // Don't care bits of bytes 2, 4 and 5 get fresh noise per frame
    task automatic buildFrame(input logic [39:0] stimFrame);
        logic [7:0] r;
        curFrame = stimFrame;
        randomBits(6, r);
        curFrame[31:26] = r[5:0];
        randomBits(6, r);
        curFrame[15:10] = r[5:0];
        randomBits(6, r);
        curFrame[7:2] = r[5:0];
    endtask

    // X is byte 4 low bits over byte 3, Y is byte 2 over byte 1
    function automatic jstkNavPkg::pos_t xOf(input logic [39:0] f);
        return {f[9:8], f[23:16]};
    endfunction

    function automatic jstkNavPkg::pos_t yOf(input logic [39:0] f);
        return {f[25:24], f[39:32]};
    endfunction

    function automatic int zoneOf(input jstkNavPkg::pos_t p);
        if (int'(p) < `JSTK_LOW_TH) return -1;
        if (int'(p) > `JSTK_HIGH_TH) return 1;
        return 0;                           // Center band
    endfunction

    // Pulses at hold offsets 0, HOLD, HOLD + REPEAT ... below d
    function automatic int pulsesBefore(input int d);
        if (d <= 0) return 0;
        if (d <= `JSTK_HOLD_CYCLES) return 1;
        return 2 + (d - 1 - `JSTK_HOLD_CYCLES) / `JSTK_REPEAT_CYCLES;
    endfunction

    // Same zone as the last test keeps the hold running
    task automatic axisExpect(input jstkNavPkg::pos_t p, input int g, input int n,
                              inout int zonePrev, inout int holdStart,
                              output int lowExp, output int highExp);
        int z;
        int a;
        int cnt;
        z = zoneOf(p);
        if (z != zonePrev) holdStart = g;
        zonePrev = z;
        a = (g - holdStart) * Poll;
        cnt = (z == 0) ? 0 : pulsesBefore(a + n * Poll) - pulsesBefore(a);
        lowExp  = (z < 0) ? cnt : 0;
        highExp = (z > 0) ? cnt : 0;
    endtask

    // ========================================================================
    // Compare tasks
    // ========================================================================

    task automatic checkBit(input logic [NameW-1:0] test, input string what,
                            input logic expV, input logic actV);
        if (actV !== expV) begin
            $display("Mismatch in %0s: %0s expected %b, actual %b", test, what, expV, actV);
            abortRun("output bit differs from its expected value");
        end
    endtask

    task automatic checkPos(input logic [NameW-1:0] test, input string what,
                            input jstkNavPkg::pos_t expV, input jstkNavPkg::pos_t actV);
        if (actV !== expV) begin
            $display("Mismatch in %0s: %0s expected %0d, actual %0d", test, what, expV, actV);
            abortRun("decoded position differs from its expected value");
        end
    endtask

    task automatic checkCount(input logic [NameW-1:0] test, input string what,
                              input int expV, input int actV);
        if (actV != expV) begin
            $display("Mismatch in %0s: %0s pulses expected %0d, actual %0d",
                     test, what, expV, actV);
            abortRun("key pulse count differs from its expected value");
        end
    endtask

    task automatic checkPulses(input logic [NameW-1:0] test,
                               input int eL, input int eR, input int eU, input int eD);
        checkCount(test, "left", eL, cntLeft);
        checkCount(test, "right", eR, cntRight);
        checkCount(test, "up", eU, cntUp);
        checkCount(test, "down", eD, cntDown);
        cntLeft  = 0;                       // Next window starts clean
        cntRight = 0;
        cntUp    = 0;
        cntDown  = 0;
    endtask

    // Counts key pulses on falling edges until SS rises
    task automatic waitFrameEnd();
        logic ssPrev;
        logic done;
        done = 1'b0;
        while (!done) begin
            ssPrev = SS;
            @(negedge CLK);
            cycles++;
            if (cycles > cycleLimit) abortRun("timeout, no SPI frame ended within the limit");
            if (left) cntLeft++;
            if (right) cntRight++;
            if (up) cntUp++;
            if (down) cntDown++;
            done = SS && !ssPrev;
        end
    endtask

    task automatic readStim();
        int               fd;
        int               n;
        int               polls;
        logic [8*128-1:0] line;
        logic [NameW-1:0] name;
        logic [7:0]       b1, b2, b3, b4, b5;
        fd = $fopen("verif/jstkNav_stim.txt", "r");
        if (fd == 0) abortRun("cannot open verif/jstkNav_stim.txt");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h %h %h %d", name, b1, b2, b3, b4, b5, polls);
            if (n == 7) begin               // Comments and blank lines skipped
                nameQ.push_back(name);
                frameQ.push_back({b1, b2, b3, b4, b5});
                pollQ.push_back(polls);
            end
        end
        $fclose(fd);
        if (nameQ.size() == 0) abortRun("stimulus file holds no tests");
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        logic [NameW-1:0] pendName;         // Test whose pulse window is open
        int               pendL, pendR, pendU, pendD;
        int               expL, expR, expU, expD;
        int               zoneX, zoneY, holdX, holdY;
        int               g;                // Polls done so far
        RST      = 1'b1;
        MISO     = 1'b0;
        curFrame = 40'h00_02_00_02_00;      // Centered until the first test
        readStim();
        cycleLimit = 0;
        foreach (pollQ[i]) cycleLimit += pollQ[i];
        cycleLimit = (cycleLimit + 1) * Poll * 2; // One extra frame closes the run
        repeat (5) @(posedge CLK);
        RST <= 1'b0;
        @(negedge CLK);
        checkBit("reset", "SS", 1'b1, SS);
        checkBit("reset", "SCLK", 1'b0, SCLK);
        checkBit("reset", "MOSI", 1'b0, MOSI);
        checkBit("reset", "left", 1'b0, left);
        checkBit("reset", "right", 1'b0, right);
        checkBit("reset", "up", 1'b0, up);
        checkBit("reset", "down", 1'b0, down);
        checkBit("reset", "click", 1'b0, click);
        checkBit("reset", "downClick", 1'b0, downClick);
        checkPos("reset", "xPos", 10'd512, i_jstkNavTop.xPos);
        checkPos("reset", "yPos", 10'd512, i_jstkNavTop.yPos);
        pendName = "reset";
        pendL = 0;
        pendR = 0;
        pendU = 0;
        pendD = 0;
        zoneX = 0;
        zoneY = 0;
        holdX = 0;
        holdY = 0;
        g = 0;
        cycles = 0;
        cntLeft = 0;
        cntRight = 0;
        cntUp = 0;
        cntDown = 0;
        foreach (nameQ[t]) begin
            axisExpect(xOf(frameQ[t]), g, pollQ[t], zoneX, holdX, expL, expR);
            axisExpect(yOf(frameQ[t]), g, pollQ[t], zoneY, holdY, expU, expD);
            for (int p = 0; p < pollQ[t]; p++) begin
                buildFrame(frameQ[t]);
                waitFrameEnd();
                if (p == 0) begin           // Previous window ends at this frame
                    checkPulses(pendName, pendL, pendR, pendU, pendD);
                    pendName = nameQ[t];
                    pendL = expL;
                    pendR = expR;
                    pendU = expU;
                    pendD = expD;
                end
                checkPos(nameQ[t], "xPos", xOf(frameQ[t]), i_jstkNavTop.xPos);
                checkPos(nameQ[t], "yPos", yOf(frameQ[t]), i_jstkNavTop.yPos);
                checkBit(nameQ[t], "click", frameQ[t][0], click);
                checkBit(nameQ[t], "downClick", frameQ[t][1], downClick);
                g++;
            end
        end
        waitFrameEnd();                     // Same frame again closes the last window
        checkPulses(pendName, pendL, pendR, pendU, pendD);
        $display("Test OK");
        $finish;
    end

endmodule

/* verif/jstkNav_chk.sv */
`timescale 1ns/1ps

module jstkNav_chk (
    input logic CLK,
    input logic RST,
    input logic SS,
    input logic SCLK,
    input logic MOSI,
    input logic left,
    input logic right,
    input logic up,
    input logic down
);

    // ========================================================================
    // SPI pins
    // ========================================================================

    sclkIdle: assert property (@(posedge CLK) disable iff (RST) SS |-> !SCLK)
        else $error("SCLK high while SS is high");

    mosiLow: assert property (@(posedge CLK) disable iff (RST) !MOSI)
        else $error("MOSI driven high");   // No command byte

    // ========================================================================
    // Key pulses
    // ========================================================================

    // One cycle wide, never back to back
    leftPulse: assert property (@(posedge CLK) disable iff (RST) left |=> !left)
        else $error("left high for two cycles");
    rightPulse: assert property (@(posedge CLK) disable iff (RST) right |=> !right)
        else $error("right high for two cycles");
    upPulse: assert property (@(posedge CLK) disable iff (RST) up |=> !up)
        else $error("up high for two cycles");
    downPulse: assert property (@(posedge CLK) disable iff (RST) down |=> !down)
        else $error("down high for two cycles");

    // Opposite keys of one axis
    xExclusive: assert property (@(posedge CLK) disable iff (RST) !(left && right))
        else $error("left and right high together");
    yExclusive: assert property (@(posedge CLK) disable iff (RST) !(up && down))
        else $error("up and down high together");

endmodule

bind jstkNavTop jstkNav_chk i_chk (
    .CLK   (CLK),
    .RST   (RST),
    .SS    (SS),
    .SCLK  (SCLK),
    .MOSI  (MOSI),
    .left  (left),
    .right (right),
    .up    (up),
    .down  (down)
);

/* verif/jstkNav_stim.txt */
# name          yLo yHi xLo xHi btn polls
# hex bytes in SPI arrival order, upper bits of yHi xHi btn filled at random
centerIdle      00  02  00  02  00  2
clickOnly       00  02  00  02  01  1
downClickOnly   00  02  00  02  02  1
bothButtons     00  02  00  02  03  1
bandEdges       2c  01  bc  02  00  1
rightTap        00  02  20  03  00  1
centerA         00  02  00  02  00  1
justOver        00  02  bd  02  01  1
centerB         00  02  00  02  00  1
leftTap         00  02  64  00  00  1
leftHold        00  02  2b  01  00  1
centerC         00  02  00  02  00  1
downHold        e8  03  00  02  00  3
downHoldMore    84  03  00  02  02  2
centerD         00  02  00  02  00  1
upHold          32  00  00  02  00  2
upToDown        ff  03  c8  00  01  2
centerE         00  02  00  02  00  1
upAgain         0a  00  00  02  00  1
centerEnd       00  02  00  02  00  1
